// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // ==============================
    // csr address map
    // ==============================
    typedef enum logic [CSR_ADDR_W-1:0] {
        // standard machine mode
        CSR_MSTATUS     = 12'h300,
        CSR_MISA        = 12'h301,
        CSR_MIE         = 12'h304,
        CSR_MTVEC       = 12'h305,
        CSR_MEPC        = 12'h341,
        CSR_MCAUSE      = 12'h342,
        CSR_MIP         = 12'h344,
        CSR_MCYCLE      = 12'hB00,
        CSR_MCYCLEH     = 12'hB80,
        CSR_MHARTID     = 12'hF14,
        // custom mvu block
        CSR_MVUWBASEPTR = 12'hF20,
        CSR_MVUIBASEPTR = 12'hF21,
        CSR_MVUSBASEPTR = 12'hF22,
        CSR_MVUBBASEPTR = 12'hF23,
        CSR_MVUOBASEPTR = 12'hF24,
        CSR_MVUPRECISION = 12'hF25,
        CSR_MVUSTATUS   = 12'hF26,
        CSR_MVUCOMMAND  = 12'hF27
    } csr_addr_e;

    // ==============================
    // access operations
    // ==============================
    typedef enum logic [2:0] {
        CSR_OP_RW    = 3'd0,
        CSR_OP_SET   = 3'd1,
        CSR_OP_CLEAR = 3'd2,
        CSR_OP_READ  = 3'd3,
        CSR_OP_MRET  = 3'd4
    } csr_op_e;

endpackage

`default_nettype wire

// ==== irq_pkg.sv ====
`default_nettype none

package irq_pkg;

    // ==============================
    // interrupt lines
    // ==============================
    localparam int IRQ_MVU = 16;

    // msip, mtip, meip and the mvu line
    localparam logic [31:0] MIE_WRITE_MASK = 32'h0001_0888;
    // only the mvu pending bit is software visible
    localparam logic [31:0] MIP_WRITE_MASK = 32'h0001_0000;

    // ==============================
    // mstatus fields
    // ==============================
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    localparam logic [31:0] MSTATUS_WRITE_MASK = 32'h0000_0088;

    // interrupt flag plus code 16
    localparam logic [31:0] CAUSE_MVU_IRQ = 32'h8000_0010;

    // mxl = 1 (rv32), base integer isa only
    localparam logic [31:0] MISA_VALUE = 32'h4000_0100;

endpackage

`default_nettype wire

// ==== csr_access_ctrl.sv ====
`default_nettype none

module csr_access_ctrl import csr_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  req_i,
    input  wire csr_op_e               op_i,
    input  wire logic [CSR_ADDR_W-1:0] addr_i,
    input  wire logic [XLEN-1:0]       wdata_i,
    output logic                       ack_o,
    output logic [XLEN-1:0]            rdata_o,
    output logic                       err_o,
    output logic [CSR_ADDR_W-1:0]      bank_addr_o,
    output logic                       wr_en_o,
    output logic [XLEN-1:0]            wr_data_o,
    output logic                       mret_o,
    input  wire logic [XLEN-1:0]       machine_rd_data_i,
    input  wire logic                  machine_hit_i,
    input  wire logic                  machine_ro_i,
    input  wire logic [XLEN-1:0]       mvu_rd_data_i,
    input  wire logic                  mvu_hit_i,
    input  wire logic                  mvu_ro_i
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP
    } state_e;

    state_e          state_q;
    logic [XLEN-1:0] old_data;
    logic            any_hit;
    logic            read_only;
    logic            is_write;
    logic            access_err;

    // ==============================
    // decode and merge
    // ==============================
    // mret reports mepc, so steer the banks there
    assign bank_addr_o = (op_i == CSR_OP_MRET) ? CSR_MEPC : addr_i;

    assign old_data   = machine_hit_i ? machine_rd_data_i : mvu_rd_data_i;
    assign any_hit    = machine_hit_i | mvu_hit_i;
    assign read_only  = machine_hit_i ? machine_ro_i : mvu_ro_i;
    assign is_write   = op_i inside {CSR_OP_RW, CSR_OP_SET, CSR_OP_CLEAR};
    assign access_err = !any_hit || (is_write && read_only);

    // read-modify-write
    always_comb begin
        case (op_i)
            CSR_OP_SET:   wr_data_o = old_data | wdata_i;
            CSR_OP_CLEAR: wr_data_o = old_data & ~wdata_i;
            default:      wr_data_o = wdata_i;
        endcase
    end

    assign wr_en_o = (state_q == ACCESS) && is_write && !access_err;
    assign mret_o  = (state_q == ACCESS) && (op_i == CSR_OP_MRET);

    // ==============================
    // handshake fsm
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) state_q <= ACCESS;
                end
                ACCESS: begin
                    err_o   <= access_err;
                    state_q <= RESP;
                end
                RESP: begin
                    // ack follows req, response held meanwhile
                    ack_o <= req_i;
                    if (!req_i) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // value seen before the write lands
    always_ff @(posedge clk) begin
        if (state_q == ACCESS) rdata_o <= old_data;
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack_o) |-> $past(req_i) && $past(req_i, 2));

    a_wr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en_o |=> !wr_en_o);

endmodule

`default_nettype wire

// ==== machine_csr_regs.sv ====
`default_nettype none

module machine_csr_regs import csr_pkg::*; import irq_pkg::*; #(
    parameter int unsigned     HART_ID   = 0,
    parameter logic [XLEN-1:0] BOOT_ADDR = '0
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [CSR_ADDR_W-1:0] addr_i,
    input  wire logic                  wr_en_i,
    input  wire logic [XLEN-1:0]       wr_data_i,
    input  wire logic                  mret_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic                  mvu_irq_i,
    input  wire logic                  count_en_i,
    output logic [XLEN-1:0]            rd_data_o,
    output logic                       hit_o,
    output logic                       read_only_o,
    output logic                       irq_take_o,
    output logic [XLEN-1:0]            irq_target_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mip_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [63:0]     mcycle_q;
    logic            irq_pending;

    assign irq_pending  = mstatus_q[MSTATUS_MIE] & mie_q[IRQ_MVU] & mip_q[IRQ_MVU];
    assign irq_target_o = mtvec_q;

    // ==============================
    // read side
    // ==============================
    always_comb begin
        rd_data_o   = '0;
        hit_o       = 1'b1;
        read_only_o = 1'b0;
        case (addr_i)
            CSR_MSTATUS: rd_data_o = mstatus_q;
            CSR_MIE:     rd_data_o = mie_q;
            CSR_MIP:     rd_data_o = mip_q;
            CSR_MTVEC:   rd_data_o = mtvec_q;
            CSR_MEPC:    rd_data_o = mepc_q;
            CSR_MCAUSE:  rd_data_o = mcause_q;
            CSR_MISA: begin
                rd_data_o   = MISA_VALUE;
                read_only_o = 1'b1;
            end
            CSR_MHARTID: begin
                rd_data_o   = XLEN'(HART_ID);
                read_only_o = 1'b1;
            end
            CSR_MCYCLE: begin
                rd_data_o   = mcycle_q[31:0];
                read_only_o = 1'b1;
            end
            CSR_MCYCLEH: begin
                rd_data_o   = mcycle_q[63:32];
                read_only_o = 1'b1;
            end
            default: hit_o = 1'b0;
        endcase
    end

    // ==============================
    // write side and trap state
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mip_q      <= '0;
            mtvec_q    <= BOOT_ADDR;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mcycle_q   <= '0;
            irq_take_o <= 1'b0;
        end else begin
            irq_take_o <= irq_pending;
            if (count_en_i) mcycle_q <= mcycle_q + 64'd1;

            if (wr_en_i && addr_i == CSR_MIE) begin
                mie_q <= (mie_q & ~MIE_WRITE_MASK) | (wr_data_i & MIE_WRITE_MASK);
            end
            if (wr_en_i && addr_i == CSR_MTVEC) mtvec_q <= wr_data_i;

            // pending bit is sticky, only software clears it
            if (wr_en_i && addr_i == CSR_MIP) begin
                mip_q <= (mip_q & ~MIP_WRITE_MASK) | (wr_data_i & MIP_WRITE_MASK);
            end
            if (mvu_irq_i) mip_q[IRQ_MVU] <= 1'b1;

            if (irq_pending) begin
                // trap entry wins over software updates
                mepc_q                  <= pc_i;
                mcause_q                <= CAUSE_MVU_IRQ;
                mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];
                mstatus_q[MSTATUS_MIE]  <= 1'b0;
            end else begin
                if (mret_i) begin
                    mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
                    mstatus_q[MSTATUS_MPIE] <= 1'b1;
                end else if (wr_en_i && addr_i == CSR_MSTATUS) begin
                    mstatus_q <= (mstatus_q & ~MSTATUS_WRITE_MASK)
                               | (wr_data_i & MSTATUS_WRITE_MASK);
                end
                if (wr_en_i && addr_i == CSR_MEPC) mepc_q <= {wr_data_i[XLEN-1:1], 1'b0};
                if (wr_en_i && addr_i == CSR_MCAUSE) mcause_q <= wr_data_i;
            end
        end
    end

    a_take_single: assert property (@(posedge clk) disable iff (!rst_n)
        irq_take_o |=> !irq_take_o);

endmodule

`default_nettype wire

// ==== mvu_csr_bank.sv ====
`default_nettype none

module mvu_csr_bank import csr_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic [CSR_ADDR_W-1:0] addr_i,
    input  wire logic                  wr_en_i,
    input  wire logic [XLEN-1:0]       wr_data_i,
    input  wire logic                  mvu_busy_i,
    output logic [XLEN-1:0]            rd_data_o,
    output logic                       hit_o,
    output logic                       read_only_o,
    output logic [XLEN-1:0]            wbaseptr_o,
    output logic [XLEN-1:0]            ibaseptr_o,
    output logic [XLEN-1:0]            sbaseptr_o,
    output logic [XLEN-1:0]            bbaseptr_o,
    output logic [XLEN-1:0]            obaseptr_o,
    output logic [XLEN-1:0]            precision_o,
    output logic [XLEN-1:0]            command_o,
    output logic                       start_o
);

    localparam int NUM_REGS = 7;
    localparam int SEL_W    = $clog2(NUM_REGS);
    localparam logic [SEL_W-1:0] SEL_CMD = SEL_W'(6);

    // slots: w, i, s, b, o base pointers, precision, command
    logic [XLEN-1:0]  regs_q [NUM_REGS];
    logic [SEL_W-1:0] sel;
    logic             sel_valid;
    logic             is_status;

    always_comb begin
        sel       = '0;
        sel_valid = 1'b1;
        is_status = 1'b0;
        case (addr_i)
            CSR_MVUWBASEPTR:  sel = SEL_W'(0);
            CSR_MVUIBASEPTR:  sel = SEL_W'(1);
            CSR_MVUSBASEPTR:  sel = SEL_W'(2);
            CSR_MVUBBASEPTR:  sel = SEL_W'(3);
            CSR_MVUOBASEPTR:  sel = SEL_W'(4);
            CSR_MVUPRECISION: sel = SEL_W'(5);
            CSR_MVUCOMMAND:   sel = SEL_CMD;
            CSR_MVUSTATUS: begin
                sel_valid = 1'b0;
                is_status = 1'b1;
            end
            default: sel_valid = 1'b0;
        endcase
    end

    assign hit_o       = sel_valid | is_status;
    assign read_only_o = is_status;
    assign rd_data_o   = is_status ? {{(XLEN-1){1'b0}}, mvu_busy_i}
                       : (sel_valid ? regs_q[sel] : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) regs_q[i] <= '0;
            start_o <= 1'b0;
        end else begin
            if (wr_en_i && sel_valid) regs_q[sel] <= wr_data_i;
            // kick the mvu once the new command is visible
            start_o <= wr_en_i && sel_valid && (sel == SEL_CMD);
        end
    end

    assign wbaseptr_o  = regs_q[0];
    assign ibaseptr_o  = regs_q[1];
    assign sbaseptr_o  = regs_q[2];
    assign bbaseptr_o  = regs_q[3];
    assign obaseptr_o  = regs_q[4];
    assign precision_o = regs_q[5];
    assign command_o   = regs_q[SEL_CMD];

    a_start_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        start_o |-> $past(wr_en_i && addr_i == CSR_MVUCOMMAND));

endmodule

`default_nettype wire

// ==== csr_unit_top.sv ====
`default_nettype none

module csr_unit_top import csr_pkg::*; #(
    parameter int unsigned     HART_ID   = 0,
    parameter logic [XLEN-1:0] BOOT_ADDR = '0
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  req_i,
    input  wire csr_op_e               op_i,
    input  wire logic [CSR_ADDR_W-1:0] addr_i,
    input  wire logic [XLEN-1:0]       wdata_i,
    input  wire logic [XLEN-1:0]       pc_i,
    input  wire logic                  mvu_irq_i,
    input  wire logic                  mvu_busy_i,
    input  wire logic                  count_en_i,
    output logic                       ack_o,
    output logic [XLEN-1:0]            rdata_o,
    output logic                       err_o,
    output logic                       irq_take_o,
    output logic [XLEN-1:0]            irq_target_o,
    output logic [XLEN-1:0]            mvu_wbaseptr_o,
    output logic [XLEN-1:0]            mvu_ibaseptr_o,
    output logic [XLEN-1:0]            mvu_sbaseptr_o,
    output logic [XLEN-1:0]            mvu_bbaseptr_o,
    output logic [XLEN-1:0]            mvu_obaseptr_o,
    output logic [XLEN-1:0]            mvu_precision_o,
    output logic [XLEN-1:0]            mvu_command_o,
    output logic                       mvu_start_o
);

    logic [CSR_ADDR_W-1:0] bank_addr;
    logic                  wr_en;
    logic [XLEN-1:0]       wr_data;
    logic                  mret;
    logic [XLEN-1:0]       machine_rd_data;
    logic                  machine_hit;
    logic                  machine_ro;
    logic [XLEN-1:0]       mvu_rd_data;
    logic                  mvu_hit;
    logic                  mvu_ro;

    csr_access_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_i             (req_i),
        .op_i              (op_i),
        .addr_i            (addr_i),
        .wdata_i           (wdata_i),
        .ack_o             (ack_o),
        .rdata_o           (rdata_o),
        .err_o             (err_o),
        .bank_addr_o       (bank_addr),
        .wr_en_o           (wr_en),
        .wr_data_o         (wr_data),
        .mret_o            (mret),
        .machine_rd_data_i (machine_rd_data),
        .machine_hit_i     (machine_hit),
        .machine_ro_i      (machine_ro),
        .mvu_rd_data_i     (mvu_rd_data),
        .mvu_hit_i         (mvu_hit),
        .mvu_ro_i          (mvu_ro)
    );

    machine_csr_regs #(
        .HART_ID   (HART_ID),
        .BOOT_ADDR (BOOT_ADDR)
    ) u_machine (
        .clk          (clk),
        .rst_n        (rst_n),
        .addr_i       (bank_addr),
        .wr_en_i      (wr_en),
        .wr_data_i    (wr_data),
        .mret_i       (mret),
        .pc_i         (pc_i),
        .mvu_irq_i    (mvu_irq_i),
        .count_en_i   (count_en_i),
        .rd_data_o    (machine_rd_data),
        .hit_o        (machine_hit),
        .read_only_o  (machine_ro),
        .irq_take_o   (irq_take_o),
        .irq_target_o (irq_target_o)
    );

    mvu_csr_bank u_mvu (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr_i      (bank_addr),
        .wr_en_i     (wr_en),
        .wr_data_i   (wr_data),
        .mvu_busy_i  (mvu_busy_i),
        .rd_data_o   (mvu_rd_data),
        .hit_o       (mvu_hit),
        .read_only_o (mvu_ro),
        .wbaseptr_o  (mvu_wbaseptr_o),
        .ibaseptr_o  (mvu_ibaseptr_o),
        .sbaseptr_o  (mvu_sbaseptr_o),
        .bbaseptr_o  (mvu_bbaseptr_o),
        .obaseptr_o  (mvu_obaseptr_o),
        .precision_o (mvu_precision_o),
        .command_o   (mvu_command_o),
        .start_o     (mvu_start_o)
    );

endmodule

`default_nettype wire

// ==== tb_csr_unit.sv ====
`default_nettype none

module tb_csr_unit import csr_pkg::*; ();

    localparam int          HART_ID         = 3;
    localparam logic [31:0] BOOT_ADDR       = 32'h0000_0080;
    localparam int          CYCLES_PER_LINE = 64;
    localparam int          EXTRA_ACCESSES  = 17;

    typedef struct packed {
        logic [2:0]  op;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic [31:0] pc;
        logic [1:0]  irq;
        logic [31:0] rdata;
        logic        err;
    } golden_t;

    logic        clk;
    logic        rst_n;
    logic        req_i;
    csr_op_e     op_i;
    logic [11:0] addr_i;
    logic [31:0] wdata_i;
    logic [31:0] pc_i;
    logic        mvu_irq_i;
    logic        mvu_busy_i;
    logic        count_en_i;
    logic        ack_o;
    logic [31:0] rdata_o;
    logic        err_o;
    logic        irq_take_o;
    logic [31:0] irq_target_o;
    logic [31:0] mvu_wbaseptr_o;
    logic [31:0] mvu_ibaseptr_o;
    logic [31:0] mvu_sbaseptr_o;
    logic [31:0] mvu_bbaseptr_o;
    logic [31:0] mvu_obaseptr_o;
    logic [31:0] mvu_precision_o;
    logic [31:0] mvu_command_o;
    logic        mvu_start_o;

    golden_t     golden_q[$];
    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    logic [31:0] exp_mtvec;
    logic        loaded;

    csr_unit_top #(
        .HART_ID   (HART_ID),
        .BOOT_ADDR (BOOT_ADDR)
    ) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_i           (req_i),
        .op_i            (op_i),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .pc_i            (pc_i),
        .mvu_irq_i       (mvu_irq_i),
        .mvu_busy_i      (mvu_busy_i),
        .count_en_i      (count_en_i),
        .ack_o           (ack_o),
        .rdata_o         (rdata_o),
        .err_o           (err_o),
        .irq_take_o      (irq_take_o),
        .irq_target_o    (irq_target_o),
        .mvu_wbaseptr_o  (mvu_wbaseptr_o),
        .mvu_ibaseptr_o  (mvu_ibaseptr_o),
        .mvu_sbaseptr_o  (mvu_sbaseptr_o),
        .mvu_bbaseptr_o  (mvu_bbaseptr_o),
        .mvu_obaseptr_o  (mvu_obaseptr_o),
        .mvu_precision_o (mvu_precision_o),
        .mvu_command_o   (mvu_command_o),
        .mvu_start_o     (mvu_start_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // helpers
    // ==============================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pointer, precision and command registers all have an output port
    function automatic logic drives_mvu_output(input logic [11:0] addr);
        return addr >= 12'hF20 && addr <= 12'hF27 && addr != 12'hF26;
    endfunction

    function automatic logic [31:0] mvu_output_for(input logic [11:0] addr);
        case (addr)
            CSR_MVUWBASEPTR:  return mvu_wbaseptr_o;
            CSR_MVUIBASEPTR:  return mvu_ibaseptr_o;
            CSR_MVUSBASEPTR:  return mvu_sbaseptr_o;
            CSR_MVUBBASEPTR:  return mvu_bbaseptr_o;
            CSR_MVUOBASEPTR:  return mvu_obaseptr_o;
            CSR_MVUPRECISION: return mvu_precision_o;
            default:          return mvu_command_o;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    task automatic load_golden();
        int               fd;
        int               n;
        int               rc;
        logic [8*128-1:0] line_buf;
        logic [31:0]      col [7];
        golden_t          g;
        fd = $fopen("csr_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("error: cannot open csr_golden.txt");
            return;
        end
        while (!$feof(fd)) begin
            line_buf = '0;
            rc = $fgets(line_buf, fd);
            // header lines fail the scan and are skipped
            n = $sscanf(line_buf, "%h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6]);
            if (rc > 0 && n == 7) begin
                g.op    = col[0][2:0];
                g.addr  = col[1][11:0];
                g.wdata = col[2];
                g.pc    = col[3];
                g.irq   = col[4][1:0];
                g.rdata = col[5];
                g.err   = col[6][0];
                golden_q.push_back(g);
            end
        end
        $fclose(fd);
    endtask

    // ==============================
    // bus master
    // ==============================
    task automatic run_handshake(input logic [2:0] op, input logic [11:0] addr,
                                 input logic [31:0] wdata, output logic [31:0] rdata,
                                 output logic err, output int starts);
        int hold;
        starts = 0;
        lcg_state = lcg_next(lcg_state);
        hold = int'(lcg_state[21:20]);
        @(posedge clk);
        req_i   <= 1'b1;
        op_i    <= csr_op_e'(op);
        addr_i  <= addr;
        wdata_i <= wdata;
        do begin
            @(negedge clk);
            if (mvu_start_o) starts++;
        end while (!ack_o);
        rdata = rdata_o;
        err   = err_o;
        // master stalls, response must stay put
        repeat (hold) begin
            @(negedge clk);
            if (mvu_start_o) starts++;
            check_true(ack_o && rdata_o === rdata, "ack or rdata changed while req was held");
        end
        @(posedge clk);
        req_i <= 1'b0;
        do begin
            @(negedge clk);
            if (mvu_start_o) starts++;
        end while (ack_o);
    endtask

    task automatic pulse_irq(input logic expect_take, input int idx);
        int takes;
        takes = 0;
        @(posedge clk);
        mvu_irq_i <= 1'b1;
        @(posedge clk);
        mvu_irq_i <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (irq_take_o) begin
                takes++;
                compare_value($sformatf("line %0d irq target", idx), exp_mtvec, irq_target_o);
            end
        end
        compare_value($sformatf("line %0d irq entries", idx), expect_take ? 1 : 0, takes);
    endtask

    task automatic run_golden_line(input int idx, input golden_t g);
        logic [31:0] rdata;
        logic        err;
        int          starts;
        int          exp_starts;
        lcg_state = lcg_next(lcg_state);
        repeat (lcg_state[17:16]) @(posedge clk);
        @(posedge clk);
        pc_i <= g.pc;
        if (g.irq != 2'd0) pulse_irq(g.irq == 2'd1, idx);
        run_handshake(g.op, g.addr, g.wdata, rdata, err, starts);
        compare_value($sformatf("line %0d rdata", idx), g.rdata, rdata);
        compare_value($sformatf("line %0d err", idx), 32'(g.err), 32'(err));
        // rw, set and clear on the command register kick the mvu
        exp_starts = (g.addr == CSR_MVUCOMMAND && g.op <= 3'd2 && !g.err) ? 1 : 0;
        compare_value($sformatf("line %0d start pulses", idx), exp_starts, starts);
        if (g.op == 3'd0 && !g.err) begin
            if (g.addr == CSR_MTVEC) exp_mtvec = g.wdata;
            if (drives_mvu_output(g.addr)) begin
                compare_value($sformatf("line %0d mvu output", idx), g.wdata,
                              mvu_output_for(g.addr));
            end
        end
    endtask

    task automatic run_extra_checks();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] rdata;
        logic        err;
        int          starts;
        int          k;
        logic [11:0] addr;
        logic [31:0] value;
        run_handshake(3'd3, CSR_MCYCLE, 32'h0, first, err, starts);
        compare_value("mcycle read err", 32'h0, 32'(err));
        run_handshake(3'd3, CSR_MCYCLE, 32'h0, second, err, starts);
        check_true(second > first, "mcycle did not increase between two reads");
        run_handshake(3'd0, CSR_MCYCLE, 32'hFFFF_FFFF, rdata, err, starts);
        compare_value("mcycle write err", 32'h1, 32'(err));
        run_handshake(3'd0, CSR_MHARTID, 32'h0000_0005, rdata, err, starts);
        compare_value("mhartid write err", 32'h1, 32'(err));
        compare_value("mhartid value", HART_ID, rdata);
        run_handshake(3'd3, CSR_MHARTID, 32'h0, rdata, err, starts);
        compare_value("mhartid after write", HART_ID, rdata);
        // golden run ends with a zero write over a pending mvu bit
        run_handshake(3'd3, CSR_MIP, 32'h0, rdata, err, starts);
        compare_value("mip after clear", 32'h0, rdata);
        // remaining pointer slots and precision
        for (k = 1; k <= 5; k++) begin
            addr  = 12'hF20 + 12'(k);
            value = {8'hC0, addr, addr};
            run_handshake(3'd0, addr, value, rdata, err, starts);
            compare_value($sformatf("mvu %h write err", addr), 32'h0, 32'(err));
            compare_value($sformatf("mvu %h start pulses", addr), 32'h0, starts);
            compare_value($sformatf("mvu %h output", addr), value, mvu_output_for(addr));
            run_handshake(3'd3, addr, 32'h0, rdata, err, starts);
            compare_value($sformatf("mvu %h read-back", addr), value, rdata);
        end
        // status tracks the busy line
        @(posedge clk);
        mvu_busy_i <= 1'b0;
        run_handshake(3'd3, CSR_MVUSTATUS, 32'h0, rdata, err, starts);
        compare_value("mvu status idle", 32'h0, rdata);
    endtask

    // ==============================
    // main sequence and watchdog
    // ==============================
    initial begin
        rst_n      = 1'b0;
        req_i      = 1'b0;
        op_i       = CSR_OP_READ;
        addr_i     = '0;
        wdata_i    = '0;
        pc_i       = '0;
        mvu_irq_i  = 1'b0;
        mvu_busy_i = 1'b1;
        count_en_i = 1'b1;
        errors     = 0;
        checks     = 0;
        lcg_state  = 32'h228b0a18;
        exp_mtvec  = BOOT_ADDR;
        loaded     = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_true(!ack_o && !err_o && !irq_take_o && !mvu_start_o,
                   "outputs not low after reset");
        foreach (golden_q[i]) run_golden_line(i, golden_q[i]);
        run_extra_checks();
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat ((golden_q.size() + EXTRA_ACCESSES) * CYCLES_PER_LINE + 8) @(posedge clk);
        $display("timeout: run did not finish, checks: %0d, errors: %0d", checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== csr_golden.txt ====
# op addr wdata pc irq exp_rdata exp_err, all hex
# op 0 rw 1 set 2 clear 3 read 4 mret, irq 0 none 1 pulse and enter 2 pulse while masked
0 f20 10000000 00000000 0 00000000 0
3 f20 00000000 00000000 0 10000000 0
0 f27 00000005 00000000 0 00000000 0
3 f26 00000000 00000000 0 00000001 0
0 f26 ffffffff 00000000 0 00000001 1
1 304 ffffffff 00000000 0 00000000 0
2 304 00000808 00000000 0 00010888 0
3 123 00000000 00000000 0 00000000 1
0 301 ffffffff 00000000 0 40000100 1
3 301 00000000 00000000 0 40000100 0
3 f14 00000000 00000000 0 00000003 0
0 305 00000200 00000000 0 00000080 0
0 300 00000008 00000000 0 00000000 0
3 341 00000000 00001234 1 00001234 0
3 342 00000000 00001234 0 80000010 0
3 300 00000000 00000000 0 00000080 0
0 344 00000000 00000000 0 00010000 0
4 000 00000000 00000000 0 00001234 0
3 300 00000000 00000000 0 00000088 0
2 304 00010000 00000000 0 00010080 0
3 344 00000000 00000000 2 00010000 0
0 344 00000000 00000000 0 00010000 0

// ==== compile.f ====
csr_pkg.sv
irq_pkg.sv
csr_access_ctrl.sv
machine_csr_regs.sv
mvu_csr_bank.sv
csr_unit_top.sv
tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - irq_pkg.sv
  - csr_access_ctrl.sv
  - machine_csr_regs.sv
  - mvu_csr_bank.sv
  - csr_unit_top.sv
  - target: test
    files:
      - tb_csr_unit.sv
